//--- design/controlUnit.sv
`default_nettype none

`include "controlUnit_config.svh"

// Decode stage top, one cycle from instruction to outputs
module controlUnit import controlUnitPkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire instrWordT            instruction,
	output controlWordT               controlWord,
	output logic [`CU_DATA_WIDTH-1:0] constant,
	output logic                      flag,
	output accessSizeT                length
);

	decodedOpT decodedOp;  // Combinational, shared by both registers

	// Opcode classification
	opcodeDecoder opcodeDecoder_inst (
		.opcode    (instruction.rView.opcode),
		.decodedOp (decodedOp)
	);

	// Constant path
	immediateGen immediateGen_inst (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.format      (decodedOp.format),
		.constant    (constant)
	);

	// Control word, flag and length
	controlWordReg controlWordReg_inst (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.decodedOp   (decodedOp),
		.controlWord (controlWord),
		.flag        (flag),
		.length      (length)
	);

endmodule

`default_nettype wire

//--- design/controlUnitPkg.sv
`default_nettype none

`include "controlUnit_config.svh"

package controlUnitPkg;

	//////////////////////////////////////////////////
	// Decoder classifications
	//////////////////////////////////////////////////

	// Instruction format, picks the field layout
	typedef enum logic [2:0] {
		fmtR    = 3'd0,  // Register-register ALU
		fmtI    = 3'd1,  // 12-bit immediate ALU
		fmtD    = 3'd2,  // Load / store
		fmtIw   = 3'd3,  // Move wide
		fmtCb   = 3'd4,  // Compare and branch
		fmtNone = 3'd5   // Opcode not recognized
	} instrFormatT;

	// ALU function select, same codes the datapath ALU expects
	typedef enum logic [4:0] {
		aluAdd = 5'b00010,
		aluSub = 5'b00110,
		aluAnd = 5'b01100,
		aluOrr = 5'b01101,
		aluEor = 5'b01110,
		aluLsl = 5'b01111,
		aluLsr = 5'b10000
	} aluFuncT;

	// Memory access size, one-hot above byte
	typedef enum logic [2:0] {
		sizeByte   = 3'b000,
		sizeHalf   = 3'b001,
		sizeWord   = 3'b010,
		sizeDouble = 3'b100
	} accessSizeT;

	//////////////////////////////////////////////////
	// Instruction word views
	//////////////////////////////////////////////////

	// R format, register operands plus shift amount
	typedef struct packed {
		logic [`CU_OPCODE_WIDTH-1:0]   opcode;  // 31..21
		logic [`CU_REG_ADDR_WIDTH-1:0] rm;      // 20..16
		logic [5:0]                    shamt;   // 15..10
		logic [`CU_REG_ADDR_WIDTH-1:0] rn;      // 9..5
		logic [`CU_REG_ADDR_WIDTH-1:0] rd;      // 4..0
	} rViewT;

	// I format, 10-bit opcode
	typedef struct packed {
		logic [9:0]                    opcode;
		logic [11:0]                   imm12;   // 21..10
		logic [`CU_REG_ADDR_WIDTH-1:0] rn;
		logic [`CU_REG_ADDR_WIDTH-1:0] rd;
	} iViewT;

	// D format, 9-bit address offset
	typedef struct packed {
		logic [`CU_OPCODE_WIDTH-1:0]   opcode;
		logic [8:0]                    addr9;   // 20..12
		logic [1:0]                    op2;
		logic [`CU_REG_ADDR_WIDTH-1:0] rn;
		logic [`CU_REG_ADDR_WIDTH-1:0] rd;
	} dViewT;

	// IW format, 16-bit move payload
	typedef struct packed {
		logic [8:0]                    opcode;
		logic [1:0]                    hw;      // Shift slot, unused here
		logic [15:0]                   imm16;   // 20..5
		logic [`CU_REG_ADDR_WIDTH-1:0] rd;
	} iwViewT;

	// One fetched word, read through whichever view the format names
	typedef union packed {
		rViewT  rView;
		iViewT  iView;
		dViewT  dView;
		iwViewT iwView;
	} instrWordT;

	//////////////////////////////////////////////////
	// Decoder results
	//////////////////////////////////////////////////

	// Per-opcode attributes, independent of register fields
	typedef struct packed {
		instrFormatT format;
		aluFuncT     aluFunc;
		logic        flagSet;   // S-variants update status
		accessSizeT  size;
		logic [1:0]  ps;        // Next-PC select
		logic        regWrite;
		logic        ramWrite;
		logic        enMem;     // Memory drives the result bus
		logic        enAlu;     // ALU drives the result bus
		logic        selB;      // B operand from constant
	} decodedOpT;

	// Control word as seen by the datapath, MSB first
	typedef struct packed {
		logic [1:0]                    ps;
		logic [`CU_REG_ADDR_WIDTH-1:0] da;
		logic [`CU_REG_ADDR_WIDTH-1:0] sa;
		logic [`CU_REG_ADDR_WIDTH-1:0] sb;
		logic [4:0]                    fs;
		logic                          regW;
		logic                          ramW;
		logic                          enMem;
		logic                          enAlu;
		logic                          enB;
		logic                          enPc;
		logic                          selB;
		logic                          pcSel;
		logic                          sl;
		logic                          carry;
	} controlWordT;

endpackage

`default_nettype wire

//--- design/controlUnit_config.svh
`ifndef CONTROL_UNIT_CONFIG_SVH
`define CONTROL_UNIT_CONFIG_SVH

//////////////////////////////////////////////////
// Decoder widths
//////////////////////////////////////////////////

// Fetched instruction word
`define CU_INSTR_WIDTH 32

// Constant bus toward the datapath, zero-extended
`define CU_DATA_WIDTH 64

// Register file index, 32 entries
`define CU_REG_ADDR_WIDTH 5

// Widest opcode field, instruction bits 31..21
// Shorter opcodes (I, IW, CB) are matched with wildcards
`define CU_OPCODE_WIDTH 11

`endif

//--- design/controlWordReg.sv
`default_nettype none

`include "controlUnit_config.svh"

// Control word assembly and output register
module controlWordReg import controlUnitPkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire instrWordT instruction,
	input  wire decodedOpT decodedOp,
	output controlWordT    controlWord,
	output logic           flag,
	output accessSizeT     length
);

	controlWordT                   nextWord;
	logic [`CU_REG_ADDR_WIDTH-1:0] srcA;
	logic [`CU_REG_ADDR_WIDTH-1:0] srcB;
	logic                          opValid;

	assign opValid = (decodedOp.format != fmtNone);

	//////////////////////////////////////////////////
	// Source register selection
	//////////////////////////////////////////////////

	always_comb begin
		srcA = '0;  // Unused ports read r0
		srcB = '0;
		case (decodedOp.format)
			fmtR: begin
				srcA = instruction.rView.rn;
				srcB = instruction.rView.rm;
			end
			fmtI: begin
				srcA = instruction.iView.rn;
			end
			fmtD: begin
				srcA = instruction.dView.rn;  // Base address
			end
			default: ;  // IW and CB read no sources
		endcase
	end

	//////////////////////////////////////////////////
	// Word assembly
	//////////////////////////////////////////////////

	always_comb begin
		nextWord       = '0;
		nextWord.ps    = decodedOp.ps;
		nextWord.da    = instruction.rView.rd;  // rd sits at 4..0 in every format
		nextWord.sa    = srcA;
		nextWord.sb    = srcB;
		nextWord.fs    = decodedOp.aluFunc;
		nextWord.regW  = decodedOp.regWrite;
		nextWord.ramW  = decodedOp.ramWrite;
		nextWord.enMem = decodedOp.enMem;
		nextWord.enAlu = decodedOp.enAlu;
		nextWord.enB   = 1'b0;
		nextWord.enPc  = 1'b0;  // No PC write without branches
		nextWord.selB  = decodedOp.selB;
		nextWord.pcSel = 1'b0;
		nextWord.sl    = 1'b1;  // Status latch always on
		nextWord.carry = 1'b0;
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			controlWord <= '0;
			flag        <= 1'b0;
			length      <= sizeByte;  // Encodes as zero
		end else if (opValid) begin
			controlWord <= nextWord;
			flag        <= decodedOp.flagSet;
			length      <= decodedOp.size;
		end
		// Unknown opcode, hold last word
	end

endmodule

`default_nettype wire

//--- design/immediateGen.sv
`default_nettype none

`include "controlUnit_config.svh"

// Constant extraction and register
module immediateGen import controlUnitPkg::*; (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire instrWordT                 instruction,
	input  wire instrFormatT               format,
	output logic [`CU_DATA_WIDTH-1:0]      constant
);

	localparam int DataWidth = `CU_DATA_WIDTH;

	always_ff @(posedge clk) begin
		if (rst) begin
			constant <= '0;
		end else begin
			// Field position depends on format
			case (format)
				fmtI: begin
					constant <= DataWidth'(instruction.iView.imm12);  // ALU immediate
				end
				fmtD: begin
					constant <= DataWidth'(instruction.dView.addr9);  // Address offset
				end
				fmtIw: begin
					constant <= DataWidth'(instruction.iwView.imm16);  // Move payload
				end
				default: begin
					// R, CB and unknown carry no immediate
					constant <= constant;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/opcodeDecoder.sv
`default_nettype none

`include "controlUnit_config.svh"

// Combinational opcode classifier
module opcodeDecoder import controlUnitPkg::*; (
	input  wire logic [`CU_OPCODE_WIDTH-1:0] opcode,
	output decodedOpT                        decodedOp
);

	// ALU-only ops, result comes off the ALU
	function automatic decodedOpT arithOp(
		input instrFormatT fmt,
		input aluFuncT     func,
		input logic        setFlags
	);
		decodedOpT op;
		op          = '0;
		op.format   = fmt;
		op.aluFunc  = func;
		op.flagSet  = setFlags;
		op.size     = sizeWord;
		op.ps       = 2'b01;
		op.regWrite = 1'b1;
		op.enAlu    = 1'b1;
		op.selB     = (fmt == fmtI);  // Immediate goes to B
		return op;
	endfunction

	// Loads and stores, address is rn + addr9
	function automatic decodedOpT memOp(
		input logic       isLoad,
		input accessSizeT size
	);
		decodedOpT op;
		op          = '0;
		op.format   = fmtD;
		op.aluFunc  = aluAdd;
		op.size     = size;
		op.ps       = (size == sizeDouble) ? 2'b00 : 2'b01;
		op.regWrite = isLoad;
		op.enMem    = isLoad;
		op.ramWrite = !isLoad;
		op.enAlu    = !isLoad;  // Store address path
		op.selB     = 1'b1;
		return op;
	endfunction

	// MOVZ / MOVK
	function automatic decodedOpT moveOp();
		decodedOpT op;
		op          = '0;
		op.format   = fmtIw;
		op.aluFunc  = aluAdd;
		op.size     = sizeWord;
		op.ps       = 2'b01;
		op.regWrite = 1'b1;
		op.enMem    = 1'b1;  // Same write-back path as a load
		op.selB     = 1'b1;
		return op;
	endfunction

	always_comb begin
		// Fallback, flagged so the registers hold
		decodedOp        = '0;
		decodedOp.format = fmtNone;

		casez (opcode)
			//////////////////////////////////////////////////
			// Arithmetic
			//////////////////////////////////////////////////
			11'b10001011000: decodedOp = arithOp(fmtR, aluAdd, 1'b0);  // ADD
			11'b11001011000: decodedOp = arithOp(fmtR, aluSub, 1'b0);  // SUB
			11'b1001000100?: decodedOp = arithOp(fmtI, aluAdd, 1'b0);  // ADDI
			11'b1101000100?: decodedOp = arithOp(fmtI, aluSub, 1'b0);  // SUBI
			11'b10101011000: decodedOp = arithOp(fmtR, aluAdd, 1'b1);  // ADDS
			11'b11101011000: decodedOp = arithOp(fmtR, aluSub, 1'b1);  // SUBS
			11'b1011000100?: decodedOp = arithOp(fmtI, aluAdd, 1'b1);  // ADDIS
			11'b1111000100?: decodedOp = arithOp(fmtI, aluSub, 1'b1);  // SUBIS

			//////////////////////////////////////////////////
			// Data transfer
			//////////////////////////////////////////////////
			11'b11111000000: decodedOp = memOp(1'b0, sizeDouble);  // STUR 64
			11'b11111000010: decodedOp = memOp(1'b1, sizeDouble);  // LDUR 64
			11'b10111000000: decodedOp = memOp(1'b0, sizeWord);    // STUR 32
			11'b10111000010: decodedOp = memOp(1'b1, sizeWord);    // LDUR 32
			11'b01111000000: decodedOp = memOp(1'b0, sizeHalf);    // STURH
			11'b01111000010: decodedOp = memOp(1'b1, sizeHalf);    // LDURH
			11'b00111000000: decodedOp = memOp(1'b0, sizeByte);    // STURB
			11'b00111000010: decodedOp = memOp(1'b1, sizeByte);    // LDURB
			11'b110100101??: decodedOp = moveOp();                 // MOVZ
			11'b111100101??: decodedOp = moveOp();                 // MOVK

			//////////////////////////////////////////////////
			// Logic and shifts
			//////////////////////////////////////////////////
			11'b10001010000: decodedOp = arithOp(fmtR, aluAnd, 1'b0);  // AND
			11'b10101010000: decodedOp = arithOp(fmtR, aluOrr, 1'b0);  // ORR
			11'b11001010000: decodedOp = arithOp(fmtR, aluEor, 1'b0);  // EOR
			11'b1001001000?: decodedOp = arithOp(fmtI, aluAnd, 1'b0);  // ANDI
			11'b1011001000?: decodedOp = arithOp(fmtI, aluOrr, 1'b0);  // ORRI
			11'b1101001000?: decodedOp = arithOp(fmtI, aluEor, 1'b0);  // EORI
			11'b11101010000: decodedOp = arithOp(fmtR, aluAnd, 1'b1);  // ANDS
			11'b1111001000?: decodedOp = arithOp(fmtI, aluAnd, 1'b1);  // ANDIS
			11'b11010011010: decodedOp = arithOp(fmtR, aluLsr, 1'b0);  // LSR
			11'b11010011011: decodedOp = arithOp(fmtR, aluLsl, 1'b0);  // LSL

			//////////////////////////////////////////////////
			// Branch
			//////////////////////////////////////////////////
			// Only CBZ decoded, other branches fall to fmtNone
			11'b10110100???: decodedOp = arithOp(fmtCb, aluAdd, 1'b0);  // CBZ

			default: ;  // Keep fmtNone
		endcase
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ns \
	-f vlog.f \
	--top-module controlUnitTb \
	-o controlUnitSim

output="$(./obj_dir/controlUnitSim)"
echo "$output"

if grep -qx "All checks passed" <<< "$output"; then
	exit 0
else
	exit 1
fi

//--- verification/controlUnitVectors.svh
`ifndef CONTROL_UNIT_VECTORS_SVH
`define CONTROL_UNIT_VECTORS_SVH

//////////////////////////////////////////////////
// Stimulus and expectation table
//////////////////////////////////////////////////

// One row per instruction, opcode left-aligned in 11 bits
typedef struct packed {
	logic [10:0] opPattern;   // Fixed top bits of the word
	logic [3:0]  fixedBits;   // How many of them are fixed
	instrFormatT format;
	aluFuncT     aluFunc;
	logic        flag;
	accessSizeT  size;
	logic [1:0]  ps;
	logic        isLoad;      // D format only
	logic        known;
} vectorT;

localparam int NumVectors = 33;

// Packs one table row
function automatic vectorT row(
	input logic [10:0] opPattern,
	input int          fixedBits,
	input instrFormatT format,
	input aluFuncT     aluFunc,
	input logic        flag,
	input accessSizeT  size,
	input logic [1:0]  ps,
	input logic        isLoad
);
	vectorT v;
	v           = '0;
	v.opPattern = opPattern;
	v.fixedBits = 4'(fixedBits);
	v.format    = format;
	v.aluFunc   = aluFunc;
	v.flag      = flag;
	v.size      = size;
	v.ps        = ps;
	v.isLoad    = isLoad;
	v.known     = (format != fmtNone);
	return v;
endfunction

// Order mixes formats so held constants get exercised
function automatic vectorT vectorAt(input int idx);
	case (idx)
		0:  return row(11'b10010001000, 10, fmtI, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // ADDI
		1:  return row(11'b10001011000, 11, fmtR, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // ADD
		2:  return row(11'b11010001000, 10, fmtI, aluSub, 1'b0, sizeWord, 2'b01, 1'b0);  // SUBI
		3:  return row(11'b11001011000, 11, fmtR, aluSub, 1'b0, sizeWord, 2'b01, 1'b0);  // SUB
		4:  return row(11'b11111000010, 11, fmtD, aluAdd, 1'b0, sizeDouble, 2'b00, 1'b1);  // LDUR
		5:  return row(11'b10110100000, 8, fmtCb, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // CBZ
		6:  return row(11'b10110001000, 10, fmtI, aluAdd, 1'b1, sizeWord, 2'b01, 1'b0);  // ADDIS
		7:  return row(11'b10101011000, 11, fmtR, aluAdd, 1'b1, sizeWord, 2'b01, 1'b0);  // ADDS
		8:  return row(11'b00010100000, 6, fmtNone, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // B
		9:  return row(11'b11110001000, 10, fmtI, aluSub, 1'b1, sizeWord, 2'b01, 1'b0);  // SUBIS
		10: return row(11'b11101011000, 11, fmtR, aluSub, 1'b1, sizeWord, 2'b01, 1'b0);  // SUBS
		11: return row(11'b11111000000, 11, fmtD, aluAdd, 1'b0, sizeDouble, 2'b00, 1'b0);  // STUR
		12: return row(11'b10010100000, 6, fmtNone, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // BL
		13: return row(11'b10010010000, 10, fmtI, aluAnd, 1'b0, sizeWord, 2'b01, 1'b0);  // ANDI
		14: return row(11'b10001010000, 11, fmtR, aluAnd, 1'b0, sizeWord, 2'b01, 1'b0);  // AND
		15: return row(11'b10110010000, 10, fmtI, aluOrr, 1'b0, sizeWord, 2'b01, 1'b0);  // ORRI
		16: return row(11'b10101010000, 11, fmtR, aluOrr, 1'b0, sizeWord, 2'b01, 1'b0);  // ORR
		17: return row(11'b10111000010, 11, fmtD, aluAdd, 1'b0, sizeWord, 2'b01, 1'b1);  // LDUR 32
		18: return row(11'b01010100000, 8, fmtNone, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // B.cond
		19: return row(11'b11010010000, 10, fmtI, aluEor, 1'b0, sizeWord, 2'b01, 1'b0);  // EORI
		20: return row(11'b11001010000, 11, fmtR, aluEor, 1'b0, sizeWord, 2'b01, 1'b0);  // EOR
		21: return row(11'b10111000000, 11, fmtD, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // STUR 32
		22: return row(11'b11110010000, 10, fmtI, aluAnd, 1'b1, sizeWord, 2'b01, 1'b0);  // ANDIS
		23: return row(11'b11101010000, 11, fmtR, aluAnd, 1'b1, sizeWord, 2'b01, 1'b0);  // ANDS
		24: return row(11'b01111000010, 11, fmtD, aluAdd, 1'b0, sizeHalf, 2'b01, 1'b1);  // LDURH
		25: return row(11'b11010011011, 11, fmtR, aluLsl, 1'b0, sizeWord, 2'b01, 1'b0);  // LSL
		26: return row(11'b01111000000, 11, fmtD, aluAdd, 1'b0, sizeHalf, 2'b01, 1'b0);  // STURH
		27: return row(11'b11010011010, 11, fmtR, aluLsr, 1'b0, sizeWord, 2'b01, 1'b0);  // LSR
		28: return row(11'b00111000010, 11, fmtD, aluAdd, 1'b0, sizeByte, 2'b01, 1'b1);  // LDURB
		29: return row(11'b11010010100, 9, fmtIw, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // MOVZ
		30: return row(11'b00111000000, 11, fmtD, aluAdd, 1'b0, sizeByte, 2'b01, 1'b0);  // STURB
		31: return row(11'b11110010100, 9, fmtIw, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // MOVK
		32: return row(11'b10110101000, 8, fmtNone, aluAdd, 1'b0, sizeWord, 2'b01, 1'b0);  // CBNZ
		default: return '0;
	endcase
endfunction

`endif

//--- verification/controlUnitTb.sv
`default_nettype none

`include "controlUnit_config.svh"

module controlUnitTb import controlUnitPkg::*; ();

	timeunit 1ns;
	timeprecision 1ns;

	`include "controlUnitVectors.svh"

	logic                      clk;
	logic                      rst;
	instrWordT                 instruction;
	controlWordT               controlWord;
	logic [`CU_DATA_WIDTH-1:0] constant;
	logic                      flag;
	accessSizeT                length;

	// Reference model state, follows the decode rules
	controlWordT               expWord;
	logic [`CU_DATA_WIDTH-1:0] expConst;
	logic                      expFlag;
	accessSizeT                expLength;

	int checkCount;
	int errorCount;

	controlUnit controlUnit_inst (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.controlWord (controlWord),
		.constant    (constant),
		.flag        (flag),
		.length      (length)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	// Two cycles per entry plus reset slack
	initial begin
		#((NumVectors + 10) * 200);
		$display("Timeout, the stimulus loop did not finish in time");
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] want);
		checkCount++;
		assert (got === want) else begin
			$display("mismatch %s: got %h expected %h", name, got, want);
			errorCount++;
		end
	endtask

	task automatic compareOutputs();
		checkValue("controlWord", 64'(controlWord), 64'(expWord));
		checkValue("constant", 64'(constant), 64'(expConst));
		checkValue("flag", 64'(flag), 64'(expFlag));
		checkValue("length", 64'(length), 64'(expLength));
	endtask

	// Next expected outputs for one applied word
	task automatic predictOutputs(input vectorT vec, input logic [31:0] word);
		controlWordT cw;
		if (vec.known) begin  // Unknown opcode holds everything
			cw    = '0;
			cw.ps = vec.ps;
			cw.da = word[4:0];  // rd
			cw.fs = vec.aluFunc;
			cw.sl = 1'b1;
			case (vec.format)
				fmtR: begin
					cw.sa    = word[9:5];
					cw.sb    = word[20:16];  // rm
					cw.regW  = 1'b1;
					cw.enAlu = 1'b1;
				end
				fmtI: begin
					cw.sa    = word[9:5];
					cw.selB  = 1'b1;
					cw.regW  = 1'b1;
					cw.enAlu = 1'b1;
					expConst = {{(`CU_DATA_WIDTH - 12){1'b0}}, word[21:10]};  // imm12
				end
				fmtD: begin
					cw.sa    = word[9:5];  // Base register
					cw.selB  = 1'b1;
					cw.regW  = vec.isLoad;
					cw.enMem = vec.isLoad;
					cw.ramW  = !vec.isLoad;
					cw.enAlu = !vec.isLoad;
					expConst = {{(`CU_DATA_WIDTH - 9){1'b0}}, word[20:12]};  // addr9
				end
				fmtIw: begin
					cw.selB  = 1'b1;
					cw.regW  = 1'b1;
					cw.enMem = 1'b1;
					expConst = {{(`CU_DATA_WIDTH - 16){1'b0}}, word[20:5]};  // imm16
				end
				fmtCb: begin
					cw.regW  = 1'b1;  // No sources, constant untouched
					cw.enAlu = 1'b1;
				end
				default: ;
			endcase
			expWord   = cw;
			expFlag   = vec.flag;
			expLength = vec.size;
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		vectorT      vec;
		logic [31:0] word;
		logic [31:0] fixedMask;
		int          errorsBefore;
		void'($urandom(47742));
		checkCount  = 0;
		errorCount  = 0;
		rst         = 1'b1;
		// ADDIS, would set every output nonzero if reset lost
		instruction = {10'b1011000100, 12'h5A3, 5'd6, 5'd9};
		expWord     = '0;
		expConst    = '0;
		expFlag     = 1'b0;
		expLength   = sizeByte;

		// Outputs cleared while reset is held
		repeat (3) begin
			@(posedge clk);
			#1;
			compareOutputs();
		end
		#4;
		rst         = 1'b0;
		instruction = '0;  // Opcode zero decodes as unknown
		@(posedge clk);
		#1;
		compareOutputs();  // Still zero right after reset
		$display("reset: %s", (errorCount == 0) ? "ok" : "error");

		for (int i = 0; i < NumVectors; i++) begin
			vec          = vectorAt(i);
			fixedMask    = 32'hFFFF_FFFF << (32 - int'(vec.fixedBits));
			word         = $urandom();
			word         = (word & ~fixedMask) | ({vec.opPattern, 21'b0} & fixedMask);
			errorsBefore = errorCount;
			@(posedge clk);
			#5 instruction = word;
			predictOutputs(vec, word);
			@(posedge clk);  // One cycle latency
			#1;
			compareOutputs();
			$display("entry %0d %s word %h: %s", i, vec.format.name(), word,
				(errorCount == errorsBefore) ? "ok" : "error");
		end

		$display("%0d entries, %0d checks, %0d errors", NumVectors, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
+incdir+verification
design/controlUnitPkg.sv
design/opcodeDecoder.sv
design/immediateGen.sv
design/controlWordReg.sv
design/controlUnit.sv
verification/controlUnitTb.sv
